// File: hw/log2_params.svh
`ifndef LOG2_PARAMS_SVH
`define LOG2_PARAMS_SVH

// Fixed point input, 16 integer bits and 8 fraction bits
`define LOG2_IN_W 24

// Exponent is the leading-one position within the integer part
`define LOG2_EXP_W 4

// Output fraction, one table entry
`define LOG2_FRAC_W 8

// Table depth is 2**LOG2_ADDR_W
`define LOG2_ADDR_W 6

// Mantissa slice taken from input bits 22 down to 2
`define LOG2_MANT_W 21

`endif

// File: hw/log2Pkg.sv
`include "log2_params.svh"

package log2Pkg;

	typedef logic [`LOG2_IN_W-1:0]   log2In_t;   // Raw sample, xxxx.yy in hex
	typedef logic [`LOG2_EXP_W-1:0]  log2Exp_t;  // Integer part of the log
	typedef logic [`LOG2_FRAC_W-1:0] log2Frac_t; // Fractional part of the log
	typedef logic [`LOG2_ADDR_W-1:0] lutAddr_t;  // Fraction table index
	typedef logic [`LOG2_MANT_W-1:0] mant_t;     // Bits below the top input bit

	// Stage 1 output, 27 bits
	typedef struct packed {
		logic     valid;
		logic     underflow; // Sample below 1.00
		log2Exp_t exp;
		mant_t    mant;      // Not yet normalized
	} encStage_t;

	// Stage 2 output, 12 bits
	typedef struct packed {
		logic     valid;
		logic     underflow;
		log2Exp_t exp;
		lutAddr_t addr;      // Six bits after the leading one
	} normStage_t;

	// Stage 3 and top level output, 14 bits
	typedef struct packed {
		logic      valid;
		logic      underflow;
		log2Exp_t  exp;
		log2Frac_t frac;
	} log2Result_t;

endpackage

// File: hw/leadingOneEncoder.sv
`timescale 1ns/1ps

module leadingOneEncoder
(
	input  logic               clk,
	input  logic               arstN,
	input  logic               inValid,   // One strobe per sample
	input  log2Pkg::log2In_t   inData,
	output log2Pkg::encStage_t stage
);
	import log2Pkg::*;

	log2Exp_t expNext;   // Leading-one position, bit 8 counts as 0
	logic     intZero;   // Nothing set in the integer part

	assign intZero = (inData[23:8] == 16'h0000);

	// Priority scan, highest set bit wins
	always_comb
	begin
		casez (inData[23:8])
			16'b1???????????????: expNext = 4'd15;
			16'b01??????????????: expNext = 4'd14;
			16'b001?????????????: expNext = 4'd13;
			16'b0001????????????: expNext = 4'd12;
			16'b00001???????????: expNext = 4'd11;
			16'b000001??????????: expNext = 4'd10;
			16'b0000001?????????: expNext = 4'd9;
			16'b00000001????????: expNext = 4'd8;
			16'b000000001???????: expNext = 4'd7;
			16'b0000000001??????: expNext = 4'd6;
			16'b00000000001?????: expNext = 4'd5;
			16'b000000000001????: expNext = 4'd4;
			16'b0000000000001???: expNext = 4'd3;
			16'b00000000000001??: expNext = 4'd2;
			16'b000000000000001?: expNext = 4'd1;
			default:              expNext = 4'd0; // Exactly 1.xx, or underflow
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			stage <= '0;
		end
		else
		begin
			stage.valid     <= inValid;
			stage.underflow <= intZero;    // Negative log, flagged only
			stage.exp       <= expNext;    // Already 0 when underflow
			stage.mant      <= inData[22:2]; // Top bit never needed after the shift
		end
	end

endmodule

// File: hw/mantissaNormalizer.sv
`timescale 1ns/1ps

`include "log2_params.svh"

module mantissaNormalizer
(
	input  logic                clk,
	input  logic                arstN,
	input  log2Pkg::encStage_t  encIn,
	output log2Pkg::normStage_t normOut
);
	import log2Pkg::*;

	mant_t    shifted;   // Leading one pushed just past the top
	lutAddr_t addrNext;

	// Shift by 15 - exp, the bit after the leading one lands on the MSB
	assign shifted = encIn.mant << ~encIn.exp;

	// Table index is the top six bits
	assign addrNext = shifted[`LOG2_MANT_W-1 -: `LOG2_ADDR_W];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			normOut <= '0;
		end
		else
		begin
			normOut.valid     <= encIn.valid;
			normOut.underflow <= encIn.underflow;
			normOut.exp       <= encIn.exp;
			normOut.addr      <= addrNext; // Don't care on underflow, masked later
		end
	end

endmodule

// File: hw/fractionLut.sv
`timescale 1ns/1ps

module fractionLut
(
	input  logic                 clk,
	input  logic                 arstN,
	input  log2Pkg::normStage_t  normIn,
	output log2Pkg::log2Result_t result
);
	import log2Pkg::*;

	log2Frac_t fracNext;   // Table output before the underflow mask

	// Entry i holds round(log2(1 + i/64) * 256)
	always_comb
	begin
		case (normIn.addr)
			6'd0:  fracNext = 8'd0;
			6'd1:  fracNext = 8'd6;
			6'd2:  fracNext = 8'd11;
			6'd3:  fracNext = 8'd17;
			6'd4:  fracNext = 8'd22;
			6'd5:  fracNext = 8'd28;
			6'd6:  fracNext = 8'd33;
			6'd7:  fracNext = 8'd38;
			6'd8:  fracNext = 8'd44;  // 43.50, rounds up
			6'd9:  fracNext = 8'd49;
			6'd10: fracNext = 8'd54;
			6'd11: fracNext = 8'd59;
			6'd12: fracNext = 8'd63;
			6'd13: fracNext = 8'd68;
			6'd14: fracNext = 8'd73;
			6'd15: fracNext = 8'd78;
			6'd16: fracNext = 8'd82;  // 1.25
			6'd17: fracNext = 8'd87;
			6'd18: fracNext = 8'd92;
			6'd19: fracNext = 8'd96;
			6'd20: fracNext = 8'd100;
			6'd21: fracNext = 8'd105;
			6'd22: fracNext = 8'd109;
			6'd23: fracNext = 8'd113;
			6'd24: fracNext = 8'd118;
			6'd25: fracNext = 8'd122;
			6'd26: fracNext = 8'd126;
			6'd27: fracNext = 8'd130;
			6'd28: fracNext = 8'd134;
			6'd29: fracNext = 8'd138;
			6'd30: fracNext = 8'd142;
			6'd31: fracNext = 8'd146;
			6'd32: fracNext = 8'd150; // 1.5
			6'd33: fracNext = 8'd154;
			6'd34: fracNext = 8'd157;
			6'd35: fracNext = 8'd161;
			6'd36: fracNext = 8'd165;
			6'd37: fracNext = 8'd169; // Just above the halfway point
			6'd38: fracNext = 8'd172;
			6'd39: fracNext = 8'd176;
			6'd40: fracNext = 8'd179;
			6'd41: fracNext = 8'd183;
			6'd42: fracNext = 8'd186;
			6'd43: fracNext = 8'd190;
			6'd44: fracNext = 8'd193;
			6'd45: fracNext = 8'd197;
			6'd46: fracNext = 8'd200;
			6'd47: fracNext = 8'd203;
			6'd48: fracNext = 8'd207; // 1.75
			6'd49: fracNext = 8'd210;
			6'd50: fracNext = 8'd213;
			6'd51: fracNext = 8'd216;
			6'd52: fracNext = 8'd220;
			6'd53: fracNext = 8'd223;
			6'd54: fracNext = 8'd226;
			6'd55: fracNext = 8'd229;
			6'd56: fracNext = 8'd232;
			6'd57: fracNext = 8'd235;
			6'd58: fracNext = 8'd238;
			6'd59: fracNext = 8'd241;
			6'd60: fracNext = 8'd244;
			6'd61: fracNext = 8'd247;
			6'd62: fracNext = 8'd250;
			6'd63: fracNext = 8'd253; // Top entry, log2 stays below 1.0
			default: fracNext = 8'd0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			result <= '0;
		end
		else
		begin
			result.valid     <= normIn.valid;
			result.underflow <= normIn.underflow;
			result.exp       <= normIn.exp;
			if (normIn.underflow)
			begin
				result.frac <= '0;      // Below 1.00, report log as zero
			end
			else
			begin
				result.frac <= fracNext;
			end
		end
	end

endmodule

// File: hw/log2Pipe.sv
`timescale 1ns/1ps

// Three-stage base-2 log, one sample per cycle
// Stage 1 finds the exponent, stage 2 normalizes, stage 3 looks up the fraction
module log2Pipe
(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 inValid,   // Sample strobe, no handshake
	input  log2Pkg::log2In_t     inData,
	output log2Pkg::log2Result_t result     // Valid three cycles after inValid
);
	import log2Pkg::*;

	encStage_t  encStage;    // Stage 1 to stage 2
	normStage_t normStage;   // Stage 2 to stage 3

	// Priority encoder and mantissa capture
	leadingOneEncoder u_encoder
	(
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.inData  (inData),
		.stage   (encStage)
	);

	// Barrel shift, table index out
	mantissaNormalizer u_normalizer
	(
		.clk     (clk),
		.arstN   (arstN),
		.encIn   (encStage),
		.normOut (normStage)
	);

	// Fraction table, registered result
	fractionLut u_lut
	(
		.clk    (clk),
		.arstN  (arstN),
		.normIn (normStage),
		.result (result)
	);

endmodule

// File: tb/log2Pipe_props.sv
`timescale 1ns/1ps

module log2Pipe_props
(
	input logic                 clk,
	input logic                 arstN,
	input logic                 inValid,
	input log2Pkg::log2In_t     inData,
	input log2Pkg::log2Result_t result
);
	import log2Pkg::*;

	int         failCount = 0;   // Read by the testbench at the end
	int         fracTable [64];  // round(log2(1 + i/64) * 256)
	logic [2:0] vPipe;           // Strobe delayed by one, two, three edges
	log2In_t    dPipe [3];       // Matching samples

	// Reference table from the math library
	initial
	begin
		for (int i = 0; i < 64; i++)
			fracTable[i] = $rtoi($ln(1.0 + i / 64.0) / $ln(2.0) * 256.0 + 0.5);
	end

	// Highest set bit of the integer part, bit 8 is exponent 0
	function automatic log2Exp_t refExp(input log2In_t s);
		log2Exp_t e;
		e = '0;
		for (int b = 8; b < 24; b++)
			if (s[b])
				e = log2Exp_t'(b - 8);
		return e;
	endfunction

	function automatic logic refUnder(input log2In_t s);
		return (s < 24'h000100); // Below 1.00
	endfunction

	// Six bits right after the leading one index the table
	function automatic log2Frac_t refFrac(input log2In_t s);
		int lead;
		int idx;
		if (refUnder(s))
			return '0;
		lead = int'(refExp(s)) + 8;
		idx  = int'((s >> (lead - 6)) & 24'h00003F);
		return log2Frac_t'(fracTable[idx]);
	endfunction

	// Latency model, cleared with the DUT
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			vPipe    <= '0;
			dPipe[0] <= '0;
			dPipe[1] <= '0;
			dPipe[2] <= '0;
		end
		else
		begin
			vPipe    <= {vPipe[1:0], inValid};
			dPipe[0] <= inData;
			dPipe[1] <= dPipe[0];
			dPipe[2] <= dPipe[1];
		end
	end

	// Valid exactly three edges after each strobe, never otherwise
	validTiming: assert property (@(posedge clk) disable iff (!arstN)
		result.valid == vPipe[2])
	else
	begin
		failCount++;
		$error("ERROR t=%0t result.valid expected %0b actual %0b", $time,
			$sampled(vPipe[2]), $sampled(result.valid));
	end

	resetClears: assert property (@(posedge clk) !arstN |-> !result.valid)
	else
	begin
		failCount++;
		$error("ERROR t=%0t result.valid expected 0 actual %0b", $time,
			$sampled(result.valid)); // Reset must flush the pipe
	end

	expCheck: assert property (@(posedge clk) disable iff (!arstN)
		result.valid |-> result.exp == refExp(dPipe[2]))
	else
	begin
		failCount++;
		$error("ERROR t=%0t result.exp expected %0d actual %0d", $time,
			refExp($sampled(dPipe[2])), $sampled(result.exp));
	end

	underCheck: assert property (@(posedge clk) disable iff (!arstN)
		result.valid |-> result.underflow == refUnder(dPipe[2]))
	else
	begin
		failCount++;
		$error("ERROR t=%0t result.underflow expected %0b actual %0b", $time,
			refUnder($sampled(dPipe[2])), $sampled(result.underflow));
	end

	fracCheck: assert property (@(posedge clk) disable iff (!arstN)
		result.valid |-> result.frac == refFrac(dPipe[2]))
	else
	begin
		failCount++;
		$error("ERROR t=%0t result.frac expected %0d actual %0d", $time,
			refFrac($sampled(dPipe[2])), $sampled(result.frac));
	end

endmodule

// File: tb/log2Pipe_tb.sv
`timescale 1ns/1ps

module log2Pipe_tb;
	import log2Pkg::*;

	localparam int clkPeriod  = 100;
	localparam int numRandom  = 200;   // Random samples, each followed by 0 to 3 idle cycles
	// Reset, idle, walking one, two sweeps, underflow, random, mid-stream reset, drain
	localparam int stimCycles = 3 + 4 + 32 + 4 + 2 * (64 + 4) + 6 + 4
		+ 4 * numRandom + 16 + 7;
	localparam int watchdogCycles = stimCycles + 20;

	logic        clk;
	logic        arstN;
	logic        inValid;
	log2In_t     inData;
	log2Result_t result;

	logic [31:0] rngState = 32'h2830;   // Xorshift seed
	int          assertErrors = 0;
	int          watchdogErrors = 0;

	log2Pipe u_log2Pipe
	(
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.inData  (inData),
		.result  (result)
	);

	// Checks live in the bound module
	bind log2Pipe log2Pipe_props u_props
	(
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.inData  (inData),
		.result  (result)
	);

	initial
		clk = 1'b0;

	always #(clkPeriod / 2) clk = ~clk;

	// 32-bit xorshift, shifts 13, 17, 5
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// One strobe, held only until the next call drives it again
	task automatic sendSample(input log2In_t s);
		@(posedge clk);
		inValid <= 1'b1;
		inData  <= s;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			inValid <= 1'b0;
			inData  <= log2In_t'(nextRandom());   // Junk data must be ignored
		end
	endtask

	task automatic resetMidStream();
		@(posedge clk);
		arstN   <= 1'b0;
		inValid <= 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
	endtask

	initial
	begin
		logic [31:0] r;
		log2In_t     sample;
		arstN   = 1'b1;
		inValid = 1'b0;
		inData  = '0;
		#1;
		arstN = 1'b0;   // Falling edge clears every stage
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		idle(4);        // No strobe yet, valid must stay low

		// Walking one, bare and then with random bits below it
		for (int b = 23; b >= 8; b--)
			sendSample(log2In_t'(1) << b);
		for (int b = 23; b >= 8; b--)
		begin
			sample = (log2In_t'(1) << b) | (log2In_t'(nextRandom()) & ((log2In_t'(1) << b) - 1));
			sendSample(sample);
		end
		idle(4);

		// Every table index at exponent 15
		for (int i = 0; i < 64; i++)
			sendSample({1'b1, lutAddr_t'(i), 17'(nextRandom())});
		idle(4);

		// And again at exponent 8, index in bits 15 to 10
		for (int i = 0; i < 64; i++)
			sendSample(24'h010000 | (log2In_t'(i) << 10) | log2In_t'(nextRandom() & 24'h3FF));
		idle(4);

		// Underflow samples, then the 1.00 boundary
		sendSample(24'h000000);
		sendSample(24'h000001);
		sendSample(24'h0000FF);
		sendSample(log2In_t'(nextRandom()) & 24'h0000FF);
		sendSample(24'h000100);   // log2 of exactly 1
		sendSample(24'h0001FF);   // Top index at exponent 0
		idle(4);

		// Random magnitudes with random gaps
		for (int n = 0; n < numRandom; n++)
		begin
			r = nextRandom();
			sample = log2In_t'(r) >> (nextRandom() % 20);
			sendSample(sample);
			idle(nextRandom() % 4);
		end

		// Reset while three samples are in flight
		for (int n = 0; n < 5; n++)
			sendSample(log2In_t'(nextRandom()));
		resetMidStream();
		idle(2);
		for (int n = 0; n < 5; n++)
			sendSample(log2In_t'(nextRandom()));
		idle(6);
		@(posedge clk);

		assertErrors = u_log2Pipe.u_props.failCount;
		$display("Errors: assertions %0d, watchdog %0d", assertErrors, watchdogErrors);
		if (assertErrors + watchdogErrors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Stops a hung run
	initial
	begin
		#(watchdogCycles * clkPeriod);
		watchdogErrors++;
		$display("Watchdog expired, stimulus did not finish within %0d cycles", watchdogCycles);
		$display("Errors: assertions %0d, watchdog %0d", u_log2Pipe.u_props.failCount,
			watchdogErrors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
+incdir+hw
hw/log2Pkg.sv
hw/leadingOneEncoder.sv
hw/mantissaNormalizer.sv
hw/fractionLut.sv
hw/log2Pipe.sv
tb/log2Pipe_props.sv
tb/log2Pipe_tb.sv

// File: Bender.yml
package:
  name: log2_pipe

sources:
  - include_dirs:
      - hw
    files:
      - hw/log2Pkg.sv
      - hw/leadingOneEncoder.sv
      - hw/mantissaNormalizer.sv
      - hw/fractionLut.sv
      - hw/log2Pipe.sv
  - target: test
    files:
      - tb/log2Pipe_props.sv
      - tb/log2Pipe_tb.sv
